// File: project.f
design/bsrCorePkg.sv
design/bsrIcTile.sv
design/bsrFetchUnit.sv
design/bsrBlockRom.sv
design/bsrFetchTop.sv
sim/bsrFetchTb.sv

// File: Bender.yml
package:
  name: bsr_fetch

sources:
  - files:
      - design/bsrCorePkg.sv
      - design/bsrIcTile.sv
      - design/bsrFetchUnit.sv
      - design/bsrBlockRom.sv
      - design/bsrFetchTop.sv
  - target: simulation
    files:
      - sim/bsrFetchTb.sv

// File: sim/bsrFetchTb.sv
`timescale 1ns/100ps

module bsrFetchTb
	import bsrCorePkg::*;
;

	localparam int clockPeriod = 10;
	localparam int opsReset = 40;	// crosses several line and block boundaries
	localparam int opsNear = 24;
	localparam int opsFar = 40;
	localparam int opsStall = 48;
	localparam int opsMix = 64;
	localparam int totalOps = opsReset + opsNear + opsFar + opsStall + opsMix;
	localparam int watchdogCycles = totalOps * (romLatency + 4) + 200;

	logic clock;
	logic reset;
	logic redirect;
	logic [31:0] redirectPc;
	logic stall;
	logic opValid;
	logic [opWidth-1:0] opWord;
	logic [31:0] opPc;

	logic [31:0] expPc;	// next opPc the stream has to deliver
	logic stallSeen;	// stall as sampled by the last rising edge
	logic redirectSeen;
	string currentTest = "reset";
	int opCount = 0;
	int errorCount = 0;
	int testsRun = 0;
	int testsFailed = 0;
	int testErrorsStart;
	int testOpsStart;

	bsrFetchTop bsrFetchTop_i (
		.clock(clock),
		.reset(reset),
		.redirect(redirect),
		.redirectPc(redirectPc),
		.stall(stall),
		.opValid(opValid),
		.opWord(opWord),
		.opPc(opPc)
	);

	initial
	begin
		clock = 1'b0;
		forever
		begin
			#(clockPeriod / 2) clock = ~clock;
		end
	end

	// halfword at byte address b is low16(b * 5) xor seed
	function automatic logic [opWidth-1:0] expectedOp(input logic [31:0] addr);
		logic [31:0] times5;
		times5 = addr * 32'd5;
		return times5[15:0] ^ romWordSeed;
	endfunction

	task automatic checkOp(input logic [opWidth-1:0] expected, input logic [opWidth-1:0] actual);
		if (actual !== expected)
		begin
			$display("CHECK FAILED %s opWord: expected %h, actual %h", currentTest, expected, actual);
			errorCount++;
		end
	endtask

	task automatic checkPc(input logic [31:0] expected, input logic [31:0] actual);
		if (actual !== expected)
		begin
			$display("CHECK FAILED %s opPc: expected %h, actual %h", currentTest, expected, actual);
			errorCount++;
		end
	endtask

	// inputs are stable at the rising edge, so record what the DUT saw there
	always @(posedge clock)
	begin
		stallSeen = stall;
		redirectSeen = redirect;
		if (reset)
		begin
			expPc = resetPc;
		end
		else if (redirect)
		begin
			expPc = redirectPc;	// stream restarts here
		end
	end

	// outputs settle after the rising edge, compare them half a cycle later
	always @(negedge clock)
	begin
		if (!reset && opValid === 1'b1)
		begin
			if (stallSeen)
			begin
				$display("%s: opcode at %h was issued while stall was high", currentTest, opPc);
				errorCount++;
			end
			if (redirectSeen)
			begin
				$display("%s: opcode at %h was issued in a redirect cycle", currentTest, opPc);
				errorCount++;
			end
			checkPc(expPc, opPc);
			checkOp(expectedOp(opPc), opWord);
			expPc = opPc + 32'd2;	// stream goes on from here
			opCount++;
		end
	end

	// random even address, either in the current block region or anywhere in memory
	function automatic logic [31:0] pickTarget();
		logic [31:0] r;
		r = $urandom;
		if (r[31])
		begin
			return {opPc[31:5], r[4:1], 1'b0};
		end
		return {12'h000, r[19:1], 1'b0};
	endfunction

	task automatic beginTest(input string name);
		@(posedge clock);
		currentTest = name;
		testErrorsStart = errorCount;
		testOpsStart = opCount;
	endtask

	task automatic endTest();
		int errs;
		@(posedge clock);
		errs = errorCount - testErrorsStart;
		testsRun++;
		if (errs != 0)
		begin
			testsFailed++;
		end
		$display("test %-14s %0d opcodes, %0d errors -> %s", currentTest,
			opCount - testOpsStart, errs, (errs == 0) ? "ok" : "bad");
	endtask

	// keeps the stream running until count more opcodes came out
	task automatic runOps(input int count, input int stallOdds, input int redirectOdds);
		int target;
		int cycles;
		int cycleLimit;
		@(posedge clock);
		target = opCount + count;
		cycleLimit = count * (romLatency + 4);
		cycles = 0;
		while (opCount < target && cycles < cycleLimit)
		begin
			@(negedge clock);
			stall = (stallOdds != 0) && ($urandom % stallOdds == 0);
			redirect = (redirectOdds != 0) && ($urandom % redirectOdds == 0);
			if (redirect)
			begin
				redirectPc = pickTarget();
			end
			@(posedge clock);
			cycles++;
		end
		@(negedge clock);
		stall = 1'b0;
		redirect = 1'b0;
		if (opCount < target)
		begin
			$display("%s: only %0d of %0d opcodes came out within %0d cycles", currentTest,
				count - (target - opCount), count, cycleLimit);
			errorCount++;
		end
	endtask

	task automatic redirectTo(input logic [31:0] target);
		@(negedge clock);
		stall = 1'b0;
		redirect = 1'b1;
		redirectPc = target;
		@(negedge clock);
		redirect = 1'b0;	// one-cycle pulse
	endtask

	initial
	begin
		int cycles;
		logic [31:0] r;
		logic [31:0] nextPc;
		reset = 1'b1;
		redirect = 1'b0;
		redirectPc = '0;
		stall = 1'b0;
		void'($urandom(29));

		// stream from pc 0 after reset
		beginTest("resetStream");
		@(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		cycles = 0;
		while (opValid !== 1'b1 && cycles <= romLatency + 6)
		begin
			@(negedge clock);
			cycles++;
		end
		if (cycles > romLatency + 2)
		begin
			$display("%s: first opcode took %0d cycles after reset, limit is %0d", currentTest,
				cycles, romLatency + 2);
			errorCount++;
		end
		runOps(opsReset, 0, 0);
		endTest();

		// redirect inside the line that is cached right now
		beginTest("nearRedirect");
		@(negedge clock);
		stall = 1'b1;
		repeat (romLatency + 4) @(negedge clock);	// let any refill for pc finish
		nextPc = opPc + 32'd2;
		r = $urandom;
		redirectTo({nextPc[31:4], r[3:1], 1'b0});
		runOps(opsNear, 0, 0);
		endTest();

		// far redirect forces a refill
		beginTest("farRedirect");
		@(negedge clock);
		r = $urandom;
		redirectTo((opPc + 32'h0004_0000 + (r & 32'h0000_0ffe)) & 32'h000f_fffe);
		runOps(opsFar, 0, 0);
		endTest();

		beginTest("randomStall");
		runOps(opsStall, 3, 0);
		endTest();

		beginTest("redirectMix");
		runOps(opsMix, 4, 10);
		endTest();

		$display("%0d tests, %0d failed, %0d opcodes checked, %0d errors", testsRun,
			testsFailed, opCount, errorCount);
		if (errorCount == 0)
		begin
			$display("TEST PASS");
		end
		else
		begin
			$display("TEST FAIL");
		end
		$finish;
	end

	// bound on the whole run, generous for misses and stalls
	initial
	begin
		#(watchdogCycles * clockPeriod);
		$display("watchdog expired after %0d cycles in test %s, the fetch stream stopped",
			watchdogCycles, currentTest);
		$display("TEST FAIL");
		$finish;
	end

endmodule

// File: design/bsrFetchTop.sv
`timescale 1ns/100ps

module bsrFetchTop
	import bsrCorePkg::*;
(
	input logic clock,
	input logic reset,

	input logic redirect,
	input logic [31:0] redirectPc,
	input logic stall,

	output logic opValid,
	output logic [opWidth-1:0] opWord,
	output logic [31:0] opPc
);

	// sequencer to tile
	logic [31:0] pc;
	logic [opWidth-1:0] pcVal;
	logic [1:0] pcOK;

	// tile to memory
	logic [memAddrWidth-1:0] memAddr;
	logic memOE;
	logic [blockWidth-1:0] memData;
	logic [1:0] memOK;

	bsrFetchUnit bsrFetchUnit_i (
		.clock(clock),
		.reset(reset),
		.redirect(redirect),
		.redirectPc(redirectPc),
		.stall(stall),
		.pcVal(pcVal),
		.pcOK(pcOK),
		.pc(pc),
		.opValid(opValid),
		.opWord(opWord),
		.opPc(opPc)
	);

	bsrIcTile bsrIcTile_i (
		.clock(clock),
		.reset(reset),
		.pc(pc),
		.pcVal(pcVal),
		.pcOK(pcOK),
		.memData(memData),
		.memOK(memOK),
		.memAddr(memAddr),
		.memOE(memOE)
	);

	bsrBlockRom bsrBlockRom_i (
		.clock(clock),
		.reset(reset),
		.memAddr(memAddr),
		.memOE(memOE),
		.memData(memData),
		.memOK(memOK)
	);

endmodule

// File: design/bsrBlockRom.sv
`timescale 1ns/100ps

module bsrBlockRom
	import bsrCorePkg::*;
(
	input logic clock,
	input logic reset,

	input logic [memAddrWidth-1:0] memAddr,	// block start, sampled when a request begins
	input logic memOE,	// request level
	output logic [blockWidth-1:0] memData,	// 32 bytes from the latched address
	output logic [1:0] memOK	// OK for exactly one cycle
);

	logic [romCountWidth-1:0] reqAge;	// request cycles already elapsed
	logic [memAddrWidth-1:0] reqAddr;	// latched request address

	// age counts memOE-high cycles and saturates once the answer is out
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			reqAge <= '0;
		end
		else if (!memOE)
		begin
			reqAge <= '0;	// request withdrawn or finished
		end
		else if (reqAge != romCountWidth'(romLatency))
		begin
			reqAge <= reqAge + 1'b1;
		end
	end

	always_ff @(posedge clock)
	begin
		if (memOE && (reqAge == '0))
		begin
			reqAddr <= memAddr;
		end
	end

	// OK in the romLatency-th cycle of the request
	always_comb
	begin
		if (memOE && (reqAge == romCountWidth'(romLatency - 1)))
		begin
			memOK = memOkOk;
		end
		else
		begin
			memOK = memOkReady;
		end
	end

	// halfword k of the block sits at byte offset 2k
	always_comb
	begin
		for (int k = 0; k < blockHalves; k++)
		begin
			memData[k * opWidth +: opWidth] = romWord(reqAddr[memAddrWidth-1:1] + (memAddrWidth - 1)'(k));
		end
	end

	// the OK cycle closes a window that opened exactly romLatency-1 cycles earlier
	assertFullWindow: assert property (
		@(posedge clock) disable iff (reset)
		(memOK == memOkOk) |-> memOE && $past(memOE, romLatency - 1)
			&& !$past(memOE, romLatency)
	);

endmodule

// File: design/bsrFetchUnit.sv
`timescale 1ns/100ps

module bsrFetchUnit
	import bsrCorePkg::*;
(
	input logic clock,
	input logic reset,

	input logic redirect,	// one-cycle pc load request
	input logic [31:0] redirectPc,	// new pc on redirect
	input logic stall,	// back-pressure from the consumer

	input logic [opWidth-1:0] pcVal,	// opcode from the tile
	input logic [1:0] pcOK,	// tile status for pc
	output logic [31:0] pc,	// current fetch address

	output logic opValid,	// one pulse per issued opcode
	output logic [opWidth-1:0] opWord,
	output logic [31:0] opPc
);

	logic issueOp;	// tile has the opcode and nothing blocks it

	// HOLD or READY from the tile just waits
	assign issueOp = (pcOK == memOkOk) && !stall && !redirect;

	// pc sequencing
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			pc <= resetPc;
		end
		else if (redirect)
		begin
			pc <= redirectPc;
		end
		else if (issueOp)
		begin
			pc <= pc + 32'd2;	// next halfword
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			opValid <= 1'b0;
		end
		else
		begin
			opValid <= issueOp;
		end
	end

	// issued opcode and its address
	always_ff @(posedge clock)
	begin
		if (issueOp)
		begin
			opWord <= pcVal;
			opPc <= pc;
		end
	end

	// a redirect cycle issues nothing, so the old stream cannot leak out after it
	assertNoIssueAfterRedirect: assert property (
		@(posedge clock) disable iff (reset)
		redirect |=> !opValid
	);

endmodule

// File: design/bsrIcTile.sv
`timescale 1ns/100ps

module bsrIcTile
	import bsrCorePkg::*;
(
	input logic clock,
	input logic reset,

	input logic [31:0] pc,	// fetch address from the sequencer
	output logic [opWidth-1:0] pcVal,	// opcode at pc
	output logic [1:0] pcOK,	// OK on hit, HOLD on miss

	input logic [blockWidth-1:0] memData,	// refill block from memory
	input logic [1:0] memOK,	// memory status
	output logic [memAddrWidth-1:0] memAddr,	// line address of the request
	output logic memOE	// request level, held until OK
);

	logic [blockWidth-1:0] blkData;	// cached 32-byte block
	logic [15:0] blkLine;	// line index of the lower half
	logic blkReady;	// block holds valid data

	logic [15:0] pcLine;	// line index of pc
	logic pcHit;
	logic blkHi;	// pc falls in the other line of the block
	logic [3:0] wordIx;	// halfword slot inside the block
	logic refillDone;	// memory answers the pending request

	assign pcLine = pc[19:4];

	// block can start on an odd line, so the upper half is not always line+1 by bit 4
	assign blkHi = blkLine[0] != pc[4];
	assign wordIx = {blkHi, pc[3:1]};

	assign pcHit = blkReady && ((pcLine == blkLine) || (pcLine == blkLine + 16'd1));

	assign refillDone = memOE && (memOK == memOkOk);

	// opcode select
	always_comb
	begin
		pcVal = blkData[wordIx * opWidth +: opWidth];
		if (pcHit)
		begin
			pcOK = memOkOk;
		end
		else
		begin
			pcOK = memOkHold;
		end
	end

	// request control
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			blkReady <= 1'b0;
			memOE <= 1'b0;
		end
		else if (memOE)
		begin
			if (refillDone)
			begin
				memOE <= 1'b0;	// drop request at the capture edge
				blkReady <= 1'b1;	// usable in the next cycle
			end
		end
		else if (!pcHit)
		begin
			memOE <= 1'b1;
			blkReady <= 1'b0;	// old block is about to be replaced
		end
	end

	// request address stays put while memOE is high,
	// so the refilled block is always tagged with the line that was asked for
	always_ff @(posedge clock)
	begin
		if (!memOE && !pcHit)
		begin
			memAddr <= {pcLine, 4'h0};
		end
	end

	// block capture
	always_ff @(posedge clock)
	begin
		if (refillDone)
		begin
			blkData <= memData;
			blkLine <= memAddr[19:4];
		end
	end

	assertNoReqOnHit: assert property (
		@(posedge clock) disable iff (reset)
		memOE |-> (pcOK != memOkOk)
	);

	// an OK answer has to come from a block that memory actually filled
	assertOkNeedsBlock: assert property (
		@(posedge clock) disable iff (reset)
		(pcOK == memOkOk) |-> !$isunknown(pcVal)
	);

endmodule

// File: design/bsrCorePkg.sv
package bsrCorePkg;

	// memory handshake status codes
	localparam logic [1:0] memOkReady = 2'b00;	// idle or not done yet
	localparam logic [1:0] memOkOk = 2'b01;	// data valid this cycle
	localparam logic [1:0] memOkHold = 2'b10;	// requester has to wait

	localparam int opWidth = 16;	// one opcode halfword
	localparam int blockWidth = 256;	// two 16-byte lines
	localparam int memAddrWidth = 20;	// byte address into memory
	localparam int blockHalves = blockWidth / opWidth;	// halfwords per block

	localparam logic [31:0] resetPc = 32'h0000_0000;	// fetch start after reset

	// block memory model
	localparam int romLatency = 3;	// request cycles up to and including OK
	localparam int romCountWidth = $clog2(romLatency + 1);
	localparam logic [opWidth-1:0] romWordSeed = 16'hA5C3;

	// content of the halfword with index halfIx, i.e. byte address 2*halfIx
	// byte address times five, low 16 bits, mixed with the seed
	function automatic logic [opWidth-1:0] romWord(input logic [memAddrWidth-2:0] halfIx);
		logic [memAddrWidth-1:0] byteAddr;
		logic [31:0] scaled;
		byteAddr = {halfIx, 1'b0};
		scaled = 32'(byteAddr) * 32'd5;
		return scaled[opWidth-1:0] ^ romWordSeed;
	endfunction

endpackage
